// File: icon_pkg.sv
`default_nettype none

package icon_pkg;

  ////////////////////////////////////////
  // scan and tile geometry
  ////////////////////////////////////////

  localparam int coord_w    = 11;                     // row, column and robot location width
  localparam int tile_shift = 6;                      // low bits inside one 64x64 robot tile

  ////////////////////////////////////////
  // memory sizes
  ////////////////////////////////////////

  localparam int sprite_addr_w   = 2 * tile_shift;    // 64x64 sprite, 4K entries
  localparam int backdrop_addr_w = 17;                // 128K backdrop entries

  // backdrop image is squashed vertically, one image row per six scan rows
  localparam int backdrop_row_div   = 6;
  localparam int backdrop_row_pitch = 1024;           // entries per image row

  localparam int load_addr_w = backdrop_addr_w;       // wide enough for either plane

  ////////////////////////////////////////
  // pixel types
  ////////////////////////////////////////

  localparam int channel_w = 4;                       // bits per colour channel

  typedef struct packed {
    logic [channel_w-1:0] blue;                       // msb nibble
    logic [channel_w-1:0] green;
    logic [channel_w-1:0] red;                        // lsb nibble
  } rgb12_t;

  typedef struct packed {
    logic   valid;                                    // pixel carries colour
    rgb12_t rgb;
  } pixel_out_t;

  // which memory a load write goes to
  typedef enum logic {
    load_sprite   = 1'b0,
    load_backdrop = 1'b1
  } load_target_e;

endpackage

`default_nettype wire

// File: pixel_load_if.sv
`timescale 1ns/1ps
`default_nettype none

// memory fill bus, one writer at the top level and one reader per memory
interface pixel_load_if;
  import icon_pkg::*;

  logic                   we;       // write strobe, always accepted
  load_target_e           target;   // selects sprite or backdrop memory
  logic [load_addr_w-1:0] addr;     // sprite memory uses the low bits only
  rgb12_t                 data;     // colour to store

  ////////////////////////////////////////
  // modports
  ////////////////////////////////////////

  modport source (
    output we,
    output target,
    output addr,
    output data
  );

  modport sink (
    input we,
    input target,
    input addr,
    input data
  );

endinterface

`default_nettype wire

// File: pixel_rom.sv
`timescale 1ns/1ps
`default_nettype none

// one image plane, synchronous read every cycle, filled over the load bus
module pixel_rom #(
  parameter type                    pixel_t = icon_pkg::rgb12_t,
  parameter int                     addr_w  = 12,
  parameter icon_pkg::load_target_e target  = icon_pkg::load_sprite
) (
  input  logic              clk,
  input  logic [addr_w-1:0] rd_addr,
  output pixel_t            rd_data,
  pixel_load_if.sink        load
);

  localparam int depth = 1 << addr_w;                 // full binary depth

  pixel_t mem [depth];                                // image storage, no reset

  logic              wr_hit;                          // write meant for this plane
  logic [addr_w-1:0] wr_addr;

  assign wr_hit  = load.we && (load.target == target);
  assign wr_addr = load.addr[addr_w-1:0];            // drop the unused upper bits

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_hit) begin
      mem[wr_addr] <= pixel_t'(load.data);           // seen by reads from the next edge on
    end
  end

  ////////////////////////////////////////
  // read port
  ////////////////////////////////////////

  // old data on a same-edge collision, new data one cycle later
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];                          // one cycle read latency
  end

endmodule

`default_nettype wire

// File: sprite_locator.sv
`timescale 1ns/1ps
`default_nettype none

// robot tile hit test and sprite address stage
module sprite_locator (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [icon_pkg::coord_w-1:0]     pixel_row,     // scan row
  input  logic [icon_pkg::coord_w-1:0]     pixel_column,  // scan column
  input  logic [icon_pkg::coord_w-1:0]     loc_x,         // robot tile column position
  input  logic [icon_pkg::coord_w-1:0]     loc_y,         // robot tile row position
  output logic                             hit,
  output logic [icon_pkg::sprite_addr_w-1:0] sprite_addr
);
  import icon_pkg::*;

  localparam int tile_w = coord_w - tile_shift;      // width of a tile number

  ////////////////////////////////////////
  // tile numbers
  ////////////////////////////////////////

  logic [tile_w-1:0] pix_tile_row;
  logic [tile_w-1:0] pix_tile_col;
  logic [tile_w-1:0] bot_tile_row;
  logic [tile_w-1:0] bot_tile_col;

  assign pix_tile_row = pixel_row[coord_w-1:tile_shift];      // upper bits pick the tile
  assign pix_tile_col = pixel_column[coord_w-1:tile_shift];
  assign bot_tile_row = loc_y[coord_w-1:tile_shift];
  assign bot_tile_col = loc_x[coord_w-1:tile_shift];

  logic hit_next;                                     // pixel falls in the robot tile

  assign hit_next = (pix_tile_row == bot_tile_row) &&
                    (pix_tile_col == bot_tile_col);

  ////////////////////////////////////////
  // offset inside the tile
  ////////////////////////////////////////

  logic [sprite_addr_w-1:0] addr_next;

  // row offset in the upper half, column offset in the lower half
  assign addr_next = {pixel_row[tile_shift-1:0], pixel_column[tile_shift-1:0]};

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit <= 1'b0;                                    // no sprite while in reset
    end else begin
      hit <= hit_next;
    end
  end

  always_ff @(posedge clk) begin
    sprite_addr <= addr_next;                         // follows the scan every cycle
  end

endmodule

`default_nettype wire

// File: backdrop_scaler.sv
`timescale 1ns/1ps
`default_nettype none

// backdrop address, image row = scan row / 6, image column = scan column
module backdrop_scaler (
  input  logic                                 clk,
  input  logic [icon_pkg::coord_w-1:0]         pixel_row,
  input  logic [icon_pkg::coord_w-1:0]         pixel_column,
  output logic [icon_pkg::backdrop_addr_w-1:0] backdrop_addr
);
  import icon_pkg::*;

  localparam int pitch_w = $clog2(backdrop_row_pitch);      // 10 for 1024 entries
  localparam int sum_w   = coord_w + pitch_w + 1;           // room for base plus column

  ////////////////////////////////////////
  // row scaling
  ////////////////////////////////////////

  logic [coord_w-1:0] image_row;                      // at most 341 for an 11 bit row

  assign image_row = pixel_row / coord_w'(backdrop_row_div);

  ////////////////////////////////////////
  // linear address
  ////////////////////////////////////////

  logic [sum_w-1:0] row_base;                         // first entry of the image row
  logic [sum_w-1:0] linear_addr;

  assign row_base = sum_w'(image_row) * sum_w'(backdrop_row_pitch);

  assign linear_addr = row_base + sum_w'(pixel_column);

  // rows past the memory wrap, only the low address bits are kept
  always_ff @(posedge clk) begin
    backdrop_addr <= linear_addr[backdrop_addr_w-1:0];
  end

endmodule

`default_nettype wire

// File: icon_overlay_top.sv
`timescale 1ns/1ps
`default_nettype none

// sprite and backdrop overlay, two cycle pixel latency
module icon_overlay_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [icon_pkg::coord_w-1:0]     pixel_row,     // scan position
  input  logic [icon_pkg::coord_w-1:0]     pixel_column,
  input  logic [icon_pkg::coord_w-1:0]     loc_x,         // robot position
  input  logic [icon_pkg::coord_w-1:0]     loc_y,
  input  logic                             load_en,       // memory fill strobe
  input  icon_pkg::load_target_e           load_target,
  input  logic [icon_pkg::load_addr_w-1:0] load_addr,
  input  icon_pkg::rgb12_t                 load_data,
  output icon_pkg::pixel_out_t             sprite_pixel,
  output icon_pkg::pixel_out_t             backdrop_pixel
);
  import icon_pkg::*;

  ////////////////////////////////////////
  // load bus
  ////////////////////////////////////////

  pixel_load_if load_bus ();

  assign load_bus.we     = load_en;                   // straight from the pins
  assign load_bus.target = load_target;
  assign load_bus.addr   = load_addr;
  assign load_bus.data   = load_data;

  ////////////////////////////////////////
  // address stage, edge n
  ////////////////////////////////////////

  logic                       sprite_hit;             // tile hit, one cycle behind the scan
  logic [sprite_addr_w-1:0]   sprite_addr;
  logic [backdrop_addr_w-1:0] backdrop_addr;

  sprite_locator u_sprite_locator (
    .clk          (clk),
    .rst_n        (rst_n),
    .pixel_row    (pixel_row),
    .pixel_column (pixel_column),
    .loc_x        (loc_x),
    .loc_y        (loc_y),
    .hit          (sprite_hit),
    .sprite_addr  (sprite_addr)
  );

  backdrop_scaler u_backdrop_scaler (
    .clk           (clk),
    .pixel_row     (pixel_row),
    .pixel_column  (pixel_column),
    .backdrop_addr (backdrop_addr)
  );

  ////////////////////////////////////////
  // memory stage, edge n+1
  ////////////////////////////////////////

  rgb12_t sprite_rgb;                                 // robot art
  rgb12_t backdrop_rgb;                               // scaled background image

  pixel_rom #(
    .pixel_t (rgb12_t),
    .addr_w  (sprite_addr_w),
    .target  (load_sprite)
  ) u_sprite_rom (
    .clk     (clk),
    .rd_addr (sprite_addr),
    .rd_data (sprite_rgb),
    .load    (load_bus.sink)
  );

  pixel_rom #(
    .pixel_t (rgb12_t),
    .addr_w  (backdrop_addr_w),
    .target  (load_backdrop)
  ) u_backdrop_rom (
    .clk     (clk),
    .rd_addr (backdrop_addr),
    .rd_data (backdrop_rgb),
    .load    (load_bus.sink)
  );

  // control flags travel beside the memory read
  logic sprite_hit_d;                                 // hit lined up with sprite_rgb
  logic backdrop_live;                                // set on the first edge out of reset
  logic backdrop_live_d;                              // lined up with backdrop_rgb

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sprite_hit_d    <= 1'b0;
      backdrop_live   <= 1'b0;
      backdrop_live_d <= 1'b0;
    end else begin
      sprite_hit_d    <= sprite_hit;
      backdrop_live   <= 1'b1;                        // stays high until the next reset
      backdrop_live_d <= backdrop_live;
    end
  end

  ////////////////////////////////////////
  // output stage, edge n+2
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sprite_pixel   <= '0;
      backdrop_pixel <= '0;
    end else begin
      if (sprite_hit_d) begin
        sprite_pixel <= '{valid: 1'b1, rgb: sprite_rgb};
      end else begin
        sprite_pixel <= '0;                           // clear lets the backdrop show through
      end
      if (backdrop_live_d) begin
        backdrop_pixel <= '{valid: 1'b1, rgb: backdrop_rgb};
      end else begin
        backdrop_pixel <= '0;                         // first two cycles after reset
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_icon_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icon_overlay;
  import icon_pkg::*;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic                   clk;
  logic                   rst_n;
  logic [coord_w-1:0]     pixel_row;
  logic [coord_w-1:0]     pixel_column;
  logic [coord_w-1:0]     loc_x;
  logic [coord_w-1:0]     loc_y;
  logic                   load_en;
  load_target_e           load_target;
  logic [load_addr_w-1:0] load_addr;
  rgb12_t                 load_data;
  pixel_out_t             sprite_pixel;
  pixel_out_t             backdrop_pixel;

  icon_overlay_top dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .pixel_row      (pixel_row),
    .pixel_column   (pixel_column),
    .loc_x          (loc_x),
    .loc_y          (loc_y),
    .load_en        (load_en),
    .load_target    (load_target),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .sprite_pixel   (sprite_pixel),
    .backdrop_pixel (backdrop_pixel)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                            // 4 ns period
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  rgb12_t     sprite_model   [1 << sprite_addr_w];    // copies of everything written
  rgb12_t     backdrop_model [1 << backdrop_addr_w];
  pixel_out_t exp_sprite     [3];                     // stage 2 lines up with the outputs
  pixel_out_t exp_backdrop   [3];

  logic   check_en;                                   // gates the output assertions
  int     errors;
  int     tests;
  int     failed_tests;
  integer seed;

  // sprite word from the tile rule with low row bits over low column bits
  function automatic pixel_out_t expect_sprite(input logic [coord_w-1:0] row,
                                               input logic [coord_w-1:0] col,
                                               input logic [coord_w-1:0] lx,
                                               input logic [coord_w-1:0] ly);
    logic [sprite_addr_w-1:0] a;
    pixel_out_t               p;
    p = '0;
    if (((row >> tile_shift) == (ly >> tile_shift)) &&
        ((col >> tile_shift) == (lx >> tile_shift))) begin
      a       = {row[tile_shift-1:0], col[tile_shift-1:0]};
      p.valid = 1'b1;
      p.rgb   = sprite_model[a];
    end
    return p;
  endfunction

  // image row is scan row / 6 and addresses past the memory wrap
  function automatic pixel_out_t expect_backdrop(input logic [coord_w-1:0] row,
                                                 input logic [coord_w-1:0] col);
    int         lin;
    pixel_out_t p;
    lin     = (int'(row) / backdrop_row_div) * backdrop_row_pitch + int'(col);
    p.valid = 1'b1;
    p.rgb   = backdrop_model[lin[backdrop_addr_w-1:0]];
    return p;
  endfunction

  // fill colour mixes all address bits including the upper ones
  function automatic rgb12_t fill_colour(input int addr, input int salt);
    int v;
    v = addr * 37 + (addr >> 12) * 11 + (addr >> 9) * 5 + salt;
    return rgb12_t'(v[11:0]);
  endfunction

  always @(posedge clk) begin
    if (load_en) begin                                // write lands before this edge's lookup
      if (load_target == load_sprite) begin
        sprite_model[load_addr[sprite_addr_w-1:0]] = load_data;
      end else begin
        backdrop_model[load_addr] = load_data;
      end
    end
    if (!rst_n) begin
      exp_sprite   <= '{default: '0};                 // reset flushes every stage
      exp_backdrop <= '{default: '0};
    end else begin
      exp_sprite[0]   <= expect_sprite(pixel_row, pixel_column, loc_x, loc_y);
      exp_sprite[1]   <= exp_sprite[0];
      exp_sprite[2]   <= exp_sprite[1];
      exp_backdrop[0] <= expect_backdrop(pixel_row, pixel_column);
      exp_backdrop[1] <= exp_backdrop[0];
      exp_backdrop[2] <= exp_backdrop[1];
    end
  end

  ////////////////////////////////////////
  // output checks
  ////////////////////////////////////////

  sprite_check: assert property (@(posedge clk) disable iff (!check_en)
    sprite_pixel == exp_sprite[2])
    else begin
      errors++;
      $display("Mismatch sprite_pixel: got %h, expected %h",
               $sampled(sprite_pixel), $sampled(exp_sprite[2]));
    end

  backdrop_check: assert property (@(posedge clk) disable iff (!check_en)
    backdrop_pixel == exp_backdrop[2])
    else begin
      errors++;
      $display("Mismatch backdrop_pixel: got %h, expected %h",
               $sampled(backdrop_pixel), $sampled(exp_backdrop[2]));
    end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #1;                                               // drive just after the edge
  endtask

  task automatic drive_pixel(input logic [coord_w-1:0] row, input logic [coord_w-1:0] col,
                             input logic [coord_w-1:0] lx, input logic [coord_w-1:0] ly);
    pixel_row    = row;
    pixel_column = col;
    loc_x        = lx;
    loc_y        = ly;
    step();
  endtask

  task automatic write_entry(input load_target_e tgt, input int addr, input rgb12_t data);
    load_en     = 1'b1;
    load_target = tgt;
    load_addr   = addr[load_addr_w-1:0];
    load_data   = data;
    step();
    load_en     = 1'b0;
  endtask

  task automatic drain();
    repeat (3) step();                                // fixed two cycle latency plus sampling
  endtask

  task automatic wait_for_backdrop_valid(input int limit);
    int n;
    n = 0;
    while (!backdrop_pixel.valid && n < limit) begin
      step();
      n++;
    end
    if (!backdrop_pixel.valid) begin
      errors++;
      $display("backdrop_pixel did not become valid within %0d cycles of reset", limit);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  function automatic logic [coord_w-1:0] rand_coord();
    return coord_w'($random(seed));
  endfunction

  // random offset inside the tile of base
  function automatic logic [coord_w-1:0] in_tile(input logic [coord_w-1:0] base);
    logic [coord_w-1:0] r;
    r = rand_coord();
    return {base[coord_w-1:tile_shift], r[tile_shift-1:0]};
  endfunction

  // neighbouring tile of base
  function automatic logic [coord_w-1:0] other_tile(input logic [coord_w-1:0] base);
    return base ^ coord_w'(1 << tile_shift);
  endfunction

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int                 e0;
    int                 pick;
    logic [coord_w-1:0] r;
    logic [coord_w-1:0] c;
    seed         = 32'hec669cf1;
    rst_n        = 1'b1;
    check_en     = 1'b0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    pixel_row    = '0;
    pixel_column = '0;
    loc_x        = '0;
    loc_y        = '0;
    load_en      = 1'b0;
    load_target  = load_sprite;
    load_addr    = '0;
    load_data    = '0;

    // both planes filled so no read returns unknown data
    for (int a = 0; a < (1 << sprite_addr_w); a++) begin
      write_entry(load_sprite, a, fill_colour(a, 5));
    end
    for (int a = 0; a < (1 << backdrop_addr_w); a++) begin
      write_entry(load_backdrop, a, fill_colour(a, 9));
    end

    e0 = errors;                                      // reset with a sprite hit held on the pins
    check_en = 1'b1;
    rst_n    = 1'b0;
    pixel_row    = 11'd100;
    pixel_column = 11'd200;
    loc_x        = 11'd200;
    loc_y        = 11'd100;
    repeat (3) step();
    rst_n = 1'b1;
    wait_for_backdrop_valid(8);
    drain();
    finish_test("reset", e0);

    e0 = errors;
    for (int i = 0; i < 300; i++) begin
      r = rand_coord();
      c = rand_coord();
      drive_pixel(r, c, in_tile(c), in_tile(r));
    end
    drain();
    finish_test("sprite_hit", e0);

    e0 = errors;
    for (int i = 0; i < 300; i++) begin
      r = rand_coord();
      c = rand_coord();
      case (i % 3)
        0:       drive_pixel(r, c, in_tile(c), other_tile(r));   // wrong row
        1:       drive_pixel(r, c, other_tile(c), in_tile(r));   // wrong column
        default: drive_pixel(r, c, other_tile(c), other_tile(r));
      endcase
    end
    drain();
    finish_test("sprite_miss", e0);

    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      r = (i < 64) ? coord_w'(2047 - i) : rand_coord();         // top rows wrap the memory
      drive_pixel(r, rand_coord(), rand_coord(), rand_coord());
    end
    drain();
    finish_test("backdrop", e0);

    e0 = errors;
    // row 12 col 300 maps to backdrop entry 2348 and sprite entry 812
    pixel_row    = 11'd12;
    pixel_column = 11'd300;
    loc_x        = 11'd300;
    loc_y        = 11'd12;
    write_entry(load_sprite, 2348, rgb12_t'(12'h5a5));
    step();
    write_entry(load_backdrop, 812, rgb12_t'(12'h3c3));
    step();
    write_entry(load_sprite, 812, rgb12_t'(12'hf0f));         // read back on the next cycle
    step();
    write_entry(load_backdrop, 2348, rgb12_t'(12'h0f0));
    step();
    drain();
    finish_test("plane_isolation", e0);

    e0 = errors;
    for (int i = 0; i < 3000; i++) begin
      r    = rand_coord();
      c    = rand_coord();
      pick = $random(seed);
      if (pick[0]) begin
        drive_pixel(r, c, in_tile(c), in_tile(r));
      end else begin
        drive_pixel(r, c, rand_coord(), rand_coord());
      end
    end
    drain();
    finish_test("random_stream", e0);

    $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
icon_pkg.sv
pixel_load_if.sv
pixel_rom.sv
sprite_locator.sv
backdrop_scaler.sv
icon_overlay_top.sv
tb_icon_overlay.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the overlay testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_icon_overlay \
  -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator returned an error"

grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
